/* hdl/icache_geom_pkg.sv */
package icache_geom_pkg;

  // Cache organisation
  localparam int num_ways = 4;
  localparam int num_sets = 8;

  localparam int addr_bits = 32;
  localparam int word_bits = 32;
  localparam int line_bits = 256;

  // Byte address split: tag | index | offset
  localparam int offset_bits = 5;
  localparam int index_bits  = 3;
  localparam int tag_bits    = addr_bits - index_bits - offset_bits;

  localparam int index_lsb = offset_bits;
  localparam int tag_lsb   = offset_bits + index_bits;

  // Word within a line, bits [4:2] of the address
  localparam int word_sel_lsb  = 2;
  localparam int word_sel_bits = offset_bits - word_sel_lsb;

  typedef logic [addr_bits-1:0]  addr_t;
  typedef logic [word_bits-1:0]  word_t;
  typedef logic [line_bits-1:0]  line_t;
  typedef logic [tag_bits-1:0]   tag_t;
  typedef logic [index_bits-1:0] index_t;

  typedef logic [word_sel_bits-1:0] word_sel_t;

  // One bit per way, used for hit, valid and load vectors
  typedef logic [num_ways-1:0] way_vec_t;

endpackage : icache_geom_pkg

/* hdl/icache_ctrl_pkg.sv */
package icache_ctrl_pkg;

  // Address that reads the arrays in the next edge
  typedef enum logic [0:0]
  {
    curr_cpu_address = 1'b0,
    prev_cpu_address = 1'b1
  } addr_sel_t;

  // Tree pseudo-LRU state, one tree per set
  //   bit 2 picks a half, bit 1 covers ways 0/1, bit 0 covers ways 2/3
  typedef logic [2:0] lru_t;

  localparam int lru_root   = 2;
  localparam int lru_pair01 = 1;
  localparam int lru_pair23 = 0;

  typedef logic [1:0] way_idx_t;

  localparam way_idx_t way_0 = 2'd0;
  localparam way_idx_t way_1 = 2'd1;
  localparam way_idx_t way_2 = 2'd2;
  localparam way_idx_t way_3 = 2'd3;

  // Root value after a hit in the low half (ways 0/1) or high half (ways 2/3)
  localparam logic root_low_used  = 1'b0;
  localparam logic root_high_used = 1'b1;

  // Pair value after a hit in the even or odd way of that pair
  localparam logic pair_even_used = 1'b0;
  localparam logic pair_odd_used  = 1'b1;

  localparam lru_t lru_reset = 3'b000;

endpackage : icache_ctrl_pkg

/* hdl/way_array.sv */
`timescale 1ns/10ps

module way_array #(
  parameter type payload_t = icache_geom_pkg::line_t
) (
  input  logic                    clk,
  input  logic                    rst,
  input  icache_geom_pkg::index_t read_index,
  input  icache_geom_pkg::index_t write_index,
  input  logic                    load,
  input  payload_t                datain,
  output payload_t                dataout
);

  payload_t mem [icache_geom_pkg::num_sets];

  // Read returns the old entry when the same set is written on that edge
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < icache_geom_pkg::num_sets; i++)
      begin
        mem[i] <= '0;
      end
      dataout <= '0;
    end
    else
    begin
      if (load)
      begin
        mem[write_index] <= datain;
      end
      dataout <= mem[read_index];
    end
  end

  load_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(load))
    else $error("way_array load is unknown");

endmodule : way_array

/* hdl/icache_lookup.sv */
`timescale 1ns/10ps

module icache_lookup (
  input  logic                       clk,
  input  logic                       rst,
  input  icache_geom_pkg::addr_t     mem_address,
  input  icache_ctrl_pkg::addr_sel_t addr_sel,
  input  icache_geom_pkg::tag_t      tags [icache_geom_pkg::num_ways],
  input  icache_geom_pkg::way_vec_t  valids,
  input  icache_ctrl_pkg::lru_t      lru,
  output icache_geom_pkg::index_t    read_index,
  output icache_geom_pkg::addr_t     prev_address,
  output logic                       hit,
  output icache_geom_pkg::way_vec_t  way_hit,
  output icache_geom_pkg::way_vec_t  valid_vec,
  output icache_ctrl_pkg::lru_t      lru_out
);

  icache_geom_pkg::addr_t sel_address;
  icache_geom_pkg::tag_t  prev_tag;

  // Held address replays a missed request
  always_comb
  begin
    if (addr_sel == icache_ctrl_pkg::prev_cpu_address)
      sel_address = prev_address;
    else
      sel_address = mem_address;
  end

  assign read_index = sel_address[icache_geom_pkg::index_lsb +: icache_geom_pkg::index_bits];

  // Sampled on the same edge as the array read, so both line up
  always_ff @(posedge clk)
  begin
    if (rst)
      prev_address <= '0;
    else
      prev_address <= sel_address;
  end

  assign prev_tag = prev_address[icache_geom_pkg::tag_lsb +: icache_geom_pkg::tag_bits];

  always_comb
  begin
    for (int i = 0; i < icache_geom_pkg::num_ways; i++)
    begin
      way_hit[i] = valids[i] && (tags[i] == prev_tag);
    end
  end

  assign hit       = |way_hit;
  assign valid_vec = valids;  // Registered with the tags, read for the same set
  assign lru_out   = lru;

  // A line is only ever filled after a miss on its tag
  single_way_hit: assert property (@(posedge clk) disable iff (rst) $onehot0(way_hit))
    else $error("more than one way hit for address %h", prev_address);

endmodule : icache_lookup

/* hdl/icache_control.sv */
`timescale 1ns/10ps

module icache_control (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       mem_read,
  input  logic                       hit,
  input  icache_geom_pkg::way_vec_t  way_hit,
  input  icache_geom_pkg::way_vec_t  valid_vec,
  input  icache_ctrl_pkg::lru_t      lru,
  input  logic                       pmem_resp,
  output logic                       mem_resp,
  output logic                       pmem_read,
  output icache_ctrl_pkg::addr_sel_t addr_sel,
  output icache_geom_pkg::way_vec_t  way_load,
  output logic                       lru_load,
  output icache_ctrl_pkg::lru_t      lru_datain
);

  typedef enum logic [1:0]
  {
    START,
    MISS,
    HIT
  } state_t;

  state_t state;
  state_t next_state;

  logic req_q;   // mem_read sampled with the address in the lookup stage
  logic filled;  // Line written and waiting for the replayed lookup

  icache_ctrl_pkg::way_idx_t fill_way;
  icache_ctrl_pkg::lru_t     lru_next;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state  <= START;
      req_q  <= 1'b0;
      filled <= 1'b0;
    end
    else
    begin
      state  <= next_state;
      req_q  <= mem_read;
      filled <= (state == MISS) && !hit && (filled || pmem_resp);
    end
  end

  // Lowest invalid way first, then the pseudo-LRU victim
  always_comb
  begin
    if (!valid_vec[0])
      fill_way = icache_ctrl_pkg::way_0;
    else if (!valid_vec[1])
      fill_way = icache_ctrl_pkg::way_1;
    else if (!valid_vec[2])
      fill_way = icache_ctrl_pkg::way_2;
    else if (!valid_vec[3])
      fill_way = icache_ctrl_pkg::way_3;
    else if (lru[icache_ctrl_pkg::lru_root] == icache_ctrl_pkg::root_low_used)
      fill_way = lru[icache_ctrl_pkg::lru_pair23] ? icache_ctrl_pkg::way_2
                                                  : icache_ctrl_pkg::way_3;
    else
      fill_way = lru[icache_ctrl_pkg::lru_pair01] ? icache_ctrl_pkg::way_0
                                                  : icache_ctrl_pkg::way_1;
  end

  // Point the tree away from the way just used
  always_comb
  begin
    lru_next = lru;
    if (way_hit[0] || way_hit[1])
    begin
      lru_next[icache_ctrl_pkg::lru_root]   = icache_ctrl_pkg::root_low_used;
      lru_next[icache_ctrl_pkg::lru_pair01] = way_hit[1] ? icache_ctrl_pkg::pair_odd_used
                                                         : icache_ctrl_pkg::pair_even_used;
    end
    else if (way_hit[2] || way_hit[3])
    begin
      lru_next[icache_ctrl_pkg::lru_root]   = icache_ctrl_pkg::root_high_used;
      lru_next[icache_ctrl_pkg::lru_pair23] = way_hit[3] ? icache_ctrl_pkg::pair_odd_used
                                                         : icache_ctrl_pkg::pair_even_used;
    end
  end

  always_comb
  begin
    next_state = state;
    mem_resp   = 1'b0;
    pmem_read  = 1'b0;
    addr_sel   = icache_ctrl_pkg::curr_cpu_address;
    way_load   = '0;

    case (state)
      START, HIT:
      begin
        if (req_q && hit)
        begin
          mem_resp   = 1'b1;
          next_state = HIT;
        end
        else if (req_q)
        begin
          addr_sel   = icache_ctrl_pkg::prev_cpu_address;  // Hold the missed address
          next_state = MISS;
        end
      end

      MISS:
      begin
        if (hit)
        begin
          mem_resp   = 1'b1;  // Replay hit takes the next address this cycle
          next_state = HIT;
        end
        else
        begin
          addr_sel  = icache_ctrl_pkg::prev_cpu_address;
          pmem_read = !filled;
          if (pmem_resp && !filled)
            way_load[fill_way] = 1'b1;
        end
      end

      default: next_state = START;
    endcase
  end

  // Every answer, replayed or not, marks its way as most recently used
  assign lru_load   = mem_resp;
  assign lru_datain = lru_next;

  // The replayed lookup hits exactly the way that was filled
  fill_one_way: assert property (@(posedge clk) disable iff (rst)
    $past(|way_load, 2) |-> way_hit == $past(way_load, 2))
    else $error("replayed lookup does not hit the single way just filled");

  pmem_read_held: assert property (@(posedge clk) disable iff (rst)
    pmem_read && !pmem_resp |=> pmem_read)
    else $error("pmem_read dropped before pmem_resp");

endmodule : icache_control

/* hdl/icache_output.sv */
`timescale 1ns/10ps

module icache_output (
  input  icache_geom_pkg::line_t     lines [icache_geom_pkg::num_ways],
  input  icache_geom_pkg::way_vec_t  way_hit,
  input  icache_geom_pkg::word_sel_t offset,
  output icache_geom_pkg::word_t     mem_rdata
);

  icache_geom_pkg::line_t hit_line;

  // AND-OR mux, way_hit is at most one-hot
  always_comb
  begin
    hit_line = '0;
    for (int i = 0; i < icache_geom_pkg::num_ways; i++)
    begin
      hit_line = hit_line | (lines[i] & {icache_geom_pkg::line_bits{way_hit[i]}});
    end
  end

  assign mem_rdata = hit_line[offset * icache_geom_pkg::word_bits +: icache_geom_pkg::word_bits];

endmodule : icache_output

/* hdl/icache.sv */
`timescale 1ns/10ps

module icache (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   mem_read,
  input  icache_geom_pkg::addr_t mem_address,
  output logic                   mem_resp,
  output icache_geom_pkg::word_t mem_rdata,
  output logic                   pmem_read,
  output icache_geom_pkg::addr_t pmem_address,
  input  logic                   pmem_resp,
  input  icache_geom_pkg::line_t pmem_rdata
);

  icache_geom_pkg::index_t    read_index;
  icache_geom_pkg::index_t    write_index;
  icache_geom_pkg::addr_t     prev_address;
  icache_geom_pkg::tag_t      fill_tag;
  icache_geom_pkg::word_sel_t word_offset;

  icache_geom_pkg::line_t     lines [icache_geom_pkg::num_ways];
  icache_geom_pkg::tag_t      tags  [icache_geom_pkg::num_ways];

  icache_geom_pkg::way_vec_t  valids;
  icache_geom_pkg::way_vec_t  valid_vec;
  icache_geom_pkg::way_vec_t  way_hit;
  icache_geom_pkg::way_vec_t  way_load;

  icache_ctrl_pkg::lru_t      lru;
  icache_ctrl_pkg::lru_t      lru_out;
  icache_ctrl_pkg::lru_t      lru_datain;
  icache_ctrl_pkg::addr_sel_t addr_sel;
  logic                       hit;
  logic                       lru_load;

  // All writes go to the set of the held address
  assign write_index = prev_address[icache_geom_pkg::index_lsb +: icache_geom_pkg::index_bits];
  assign fill_tag    = prev_address[icache_geom_pkg::tag_lsb +: icache_geom_pkg::tag_bits];
  assign word_offset = prev_address[icache_geom_pkg::word_sel_lsb +: icache_geom_pkg::word_sel_bits];
  assign pmem_address = {prev_address[icache_geom_pkg::addr_bits-1:icache_geom_pkg::offset_bits],
                         {icache_geom_pkg::offset_bits{1'b0}}};

  for (genvar i = 0; i < icache_geom_pkg::num_ways; i++)
  begin : g_way
    way_array #(.payload_t(icache_geom_pkg::line_t)) data_array (
      .clk(clk), .rst(rst), .read_index(read_index), .write_index(write_index),
      .load(way_load[i]), .datain(pmem_rdata), .dataout(lines[i])
    );

    way_array #(.payload_t(icache_geom_pkg::tag_t)) tag_array (
      .clk(clk), .rst(rst), .read_index(read_index), .write_index(write_index),
      .load(way_load[i]), .datain(fill_tag), .dataout(tags[i])
    );
  end

  way_array #(.payload_t(icache_geom_pkg::way_vec_t)) valid_array (
    .clk(clk), .rst(rst), .read_index(read_index), .write_index(write_index),
    .load(|way_load), .datain(valid_vec | way_load), .dataout(valids)
  );

  way_array #(.payload_t(icache_ctrl_pkg::lru_t)) lru_array (
    .clk(clk), .rst(rst), .read_index(read_index), .write_index(write_index),
    .load(lru_load), .datain(lru_datain), .dataout(lru)
  );

  icache_lookup lookup (
    .clk(clk), .rst(rst), .mem_address(mem_address), .addr_sel(addr_sel),
    .tags(tags), .valids(valids), .lru(lru), .read_index(read_index),
    .prev_address(prev_address), .hit(hit), .way_hit(way_hit),
    .valid_vec(valid_vec), .lru_out(lru_out)
  );

  icache_control control (
    .clk(clk), .rst(rst), .mem_read(mem_read), .hit(hit), .way_hit(way_hit),
    .valid_vec(valid_vec), .lru(lru_out), .pmem_resp(pmem_resp),
    .mem_resp(mem_resp), .pmem_read(pmem_read), .addr_sel(addr_sel),
    .way_load(way_load), .lru_load(lru_load), .lru_datain(lru_datain)
  );

  icache_output out_sel (
    .lines(lines), .way_hit(way_hit), .offset(word_offset), .mem_rdata(mem_rdata)
  );

endmodule : icache

/* tests/tb_icache_tasks.svh */
`ifndef TB_ICACHE_TASKS_SVH
`define TB_ICACHE_TASKS_SVH

function logic [31:0] xorshift();
  rng_state ^= rng_state << 13;
  rng_state ^= rng_state >> 17;
  rng_state ^= rng_state << 5;
  return rng_state;
endfunction

function icache_geom_pkg::addr_t make_addr(input int tag, input int set, input int word);
  return {icache_geom_pkg::tag_t'(tag), icache_geom_pkg::index_t'(set),
          icache_geom_pkg::word_sel_t'(word), 2'b00};
endfunction

function icache_geom_pkg::word_t model_word(input icache_geom_pkg::addr_t a);
  return {a[31:2], 2'b00} ^ word_key;
endfunction

function icache_geom_pkg::line_t model_line(input icache_geom_pkg::addr_t a);
  icache_geom_pkg::line_t line;
  icache_geom_pkg::addr_t base;
  base = {a[31:5], 5'b00000};
  for (int w = 0; w < 8; w++)
    line[w * 32 +: 32] = model_word(base + 4 * w);
  return line;
endfunction

function icache_ctrl_pkg::lru_t lru_after(input icache_ctrl_pkg::lru_t l, input int way);
  case (way)
    0: begin l[2] = 1'b0; l[1] = 1'b0; end
    1: begin l[2] = 1'b0; l[1] = 1'b1; end
    2: begin l[2] = 1'b1; l[0] = 1'b0; end
    default: begin l[2] = 1'b1; l[0] = 1'b1; end
  endcase
  return l;
endfunction

function int model_victim(input int set);
  for (int w = 0; w < icache_geom_pkg::num_ways; w++)
    if (!model_valid[set][w])
      return w;
  if (!model_lru[set][2])
    return model_lru[set][0] ? 2 : 3;
  return model_lru[set][1] ? 0 : 1;
endfunction

task automatic model_clear();
  for (int s = 0; s < icache_geom_pkg::num_sets; s++)
  begin
    model_lru[s] = '0;
    for (int w = 0; w < icache_geom_pkg::num_ways; w++)
    begin
      model_valid[s][w] = 1'b0;
      model_tag[s][w]   = '0;
    end
  end
endtask

// The replayed request after a fill counts as a hit on the new way
task automatic model_access(input icache_geom_pkg::addr_t a, output bit miss);
  int set;
  int way;
  icache_geom_pkg::tag_t tag;
  set = int'(a[7:5]);
  tag = a[31:8];
  way = -1;
  for (int w = 0; w < icache_geom_pkg::num_ways; w++)
    if (model_valid[set][w] && model_tag[set][w] == tag)
      way = w;
  miss = (way < 0);
  if (miss)
  begin
    way = model_victim(set);
    model_valid[set][way] = 1'b1;
    model_tag[set][way]   = tag;
  end
  model_lru[set] = lru_after(model_lru[set], way);
endtask

task automatic check_word(input string name, input icache_geom_pkg::word_t expected,
                          input icache_geom_pkg::word_t actual);
  if (expected !== actual)
  begin
    $display("MISMATCH %s expected %h actual %h", name, expected, actual);
    errors++;
  end
endtask

task automatic check_addr(input string name, input icache_geom_pkg::addr_t expected,
                          input icache_geom_pkg::addr_t actual);
  if (expected !== actual)
  begin
    $display("MISMATCH %s expected %h actual %h", name, expected, actual);
    errors++;
  end
endtask

task automatic check_count(input string name, input int expected, input int actual);
  if (expected != actual)
  begin
    $display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
    errors++;
  end
endtask

task automatic do_reset();
  rst <= 1'b1;
  repeat (16) @(posedge clk);
  rst <= 1'b0;
  @(posedge clk);
  model_clear();
endtask

task automatic read_word(input icache_geom_pkg::addr_t addr, output icache_geom_pkg::word_t data);
  int cycles;
  cycles = 0;
  mem_read    <= 1'b1;
  mem_address <= addr;
  do
  begin
    @(posedge clk);
    cycles++;
  end while (!mem_resp && cycles < 200);
  if (!mem_resp)
  begin
    $display("No mem_resp within 200 cycles for address %h", addr);
    errors++;
  end
  data = mem_rdata;
  mem_read <= 1'b0;
  @(posedge clk);  // Address is sampled once more on the answer edge
endtask

task automatic access(input icache_geom_pkg::addr_t addr, input string name);
  bit miss;
  int rises_before;
  icache_geom_pkg::word_t data;
  model_access(addr, miss);
  rises_before = pmem_rises;
  read_word(addr, data);
  check_word(name, model_word(addr), data);
  check_count({name, " line fetches"}, int'(miss), pmem_rises - rises_before);
  // Memory is asked for the line that holds the requested byte
  if (miss)
    check_addr({name, " line address"}, addr & 32'hffff_ffe0, fetched_address);
endtask

task automatic cold_miss_test();
  for (int i = 0; i < 4; i++)
    access(make_addr('h100 + i, i, i), "cold_miss");
endtask

task automatic hit_reuse_test();
  int rises_before;
  rises_before = pmem_rises;
  for (int w = 0; w < 8; w++)
    access(make_addr('h100, 0, w), "hit_reuse");
  check_count("hit_reuse total fetches", 0, pmem_rises - rises_before);
endtask

// Hit stream in sets 6 and 7, one new address per clock
task automatic back_to_back_test();
  icache_geom_pkg::addr_t addrs [16];
  int rises_before;
  access(make_addr('h200, 6, 0), "back_to_back_fill");
  access(make_addr('h201, 7, 0), "back_to_back_fill");
  for (int i = 0; i < 16; i++)
    addrs[i] = make_addr('h200 + i % 2, 6 + i % 2, (i * 3) % 8);
  rises_before = pmem_rises;
  for (int k = 0; k < 18; k++)
  begin
    if (k >= 2)
    begin
      check_count("back_to_back mem_resp", 1, int'(mem_resp));
      check_word("back_to_back", model_word(addrs[k - 2]), mem_rdata);
    end
    if (k < 16)
    begin
      mem_read    <= 1'b1;
      mem_address <= addrs[k];
    end
    else
      mem_read <= 1'b0;
    @(posedge clk);
  end
  check_count("back_to_back fetches", 0, pmem_rises - rises_before);
endtask

task automatic replacement_test();
  int victim;
  icache_geom_pkg::tag_t evicted;
  for (int t = 0; t < 4; t++)
    access(make_addr('h300 + t, 5, t), "replace_fill");
  access(make_addr('h300, 5, 1), "replace_hit");
  access(make_addr('h302, 5, 2), "replace_hit");
  access(make_addr('h301, 5, 3), "replace_hit");
  victim  = model_victim(5);
  evicted = model_tag[5][victim];
  access(make_addr('h304, 5, 4), "replace_new");
  for (int t = 0; t < 4; t++)
    if (icache_geom_pkg::tag_t'('h300 + t) != evicted)
      access(make_addr('h300 + t, 5, 5), "replace_survivor");
  access(make_addr(int'(evicted), 5, 6), "replace_evicted");
endtask

task automatic reset_test();
  icache_geom_pkg::addr_t a;
  a = make_addr('h100, 0, 0);
  access(a, "reset_before");
  do_reset();
  repeat (4)
  begin
    @(posedge clk);
    check_count("reset idle mem_resp", 0, int'(mem_resp));
    check_count("reset idle pmem_read", 0, int'(pmem_read));
  end
  access(a, "reset_after");
endtask

task automatic random_latency_test();
  int tag;
  int set;
  int word;
  for (int i = 0; i < 40; i++)
  begin
    tag  = 'h400 + int'(xorshift() % 5);
    set  = int'(xorshift() % 3);
    word = int'(xorshift() % 8);
    access(make_addr(tag, set, word), "random_latency");
  end
endtask

`endif

/* tests/tb_icache.sv */
`timescale 1ns/10ps

module tb_icache;

  localparam int clk_period     = 8;
  localparam int num_accesses   = 4 + 8 + 18 + 12 + 2 + 40;  // Reads issued by each test in turn
  localparam int timeout_cycles = num_accesses * 12 + 2000;

  localparam icache_geom_pkg::word_t word_key = 32'h5a3c_96e1;  // Memory content key

  logic                   clk = 1'b0;
  logic                   rst = 1'b1;
  logic                   mem_read = 1'b0;
  icache_geom_pkg::addr_t mem_address = '0;
  logic                   mem_resp;
  icache_geom_pkg::word_t mem_rdata;
  logic                   pmem_read;
  icache_geom_pkg::addr_t pmem_address;
  logic                   pmem_resp = 1'b0;
  icache_geom_pkg::line_t pmem_rdata = '0;

  int          errors = 0;
  int          pmem_rises = 0;
  logic        pmem_read_q = 1'b0;
  logic [31:0] rng_state = 32'd12019;
  int          delay_left = -1;

  icache_geom_pkg::addr_t fetched_address = '0;  // Line address seen by the memory

  // Reference model of the tag store, valid bits and tree state
  logic                  model_valid [icache_geom_pkg::num_sets][icache_geom_pkg::num_ways];
  icache_geom_pkg::tag_t model_tag   [icache_geom_pkg::num_sets][icache_geom_pkg::num_ways];
  icache_ctrl_pkg::lru_t model_lru   [icache_geom_pkg::num_sets];

  icache icache_inst (
    .clk(clk),
    .rst(rst),
    .mem_read(mem_read),
    .mem_address(mem_address),
    .mem_resp(mem_resp),
    .mem_rdata(mem_rdata),
    .pmem_read(pmem_read),
    .pmem_address(pmem_address),
    .pmem_resp(pmem_resp),
    .pmem_rdata(pmem_rdata)
  );

  `include "tb_icache_tasks.svh"

  initial
  begin
    forever #(clk_period / 2) clk = ~clk;
  end

  // Counts line requests
  initial
  begin
    forever
    begin
      @(posedge clk);
      if (pmem_read && !pmem_read_q)
        pmem_rises++;
      pmem_read_q = pmem_read;
    end
  end

  // Line memory, answers after 1 to 6 cycles
  initial
  begin
    forever
    begin
      @(posedge clk);
      pmem_resp <= 1'b0;
      if (rst)
        delay_left = -1;
      else if (pmem_read && !pmem_resp)
      begin
        if (delay_left < 0)
          delay_left = 1 + int'(xorshift() % 6);
        delay_left--;
        if (delay_left == 0)
        begin
          fetched_address = pmem_address;
          pmem_rdata <= model_line(pmem_address);
          pmem_resp  <= 1'b1;
          delay_left = -1;
        end
      end
    end
  end

  initial
  begin
    #(timeout_cycles * clk_period);
    $display("Watchdog expired after %0d cycles before the tests ended", timeout_cycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial
  begin
    model_clear();
    do_reset();
    cold_miss_test();
    hit_reuse_test();
    back_to_back_test();
    replacement_test();
    reset_test();
    random_latency_test();
    $display("Tests done, errors: %0d", errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule : tb_icache

/* all.f */
+incdir+tests
hdl/icache_geom_pkg.sv
hdl/icache_ctrl_pkg.sv
hdl/way_array.sv
hdl/icache_lookup.sv
hdl/icache_control.sv
hdl/icache_output.sv
hdl/icache.sv
tests/tb_icache.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_icache
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
